// ==== Bender.yml ====
package:
  name: scratchpad

sources:
  # packages first, the RTL depends on both
  - logic/spad_isa_pkg.sv
  - logic/spad_pkg.sv
  - logic/sync_fifo.sv
  - logic/spad_bank.sv
  - logic/bank_access_fsm.sv
  - logic/scratchpad_top.sv
  - target: test
    files:
      - dv/scratchpad_tb.sv

// ==== dv/scratchpad_tb.sv ====
`default_nettype none

module scratchpad_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import spad_isa_pkg::*;
    import spad_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int N_INSTR = 20;
    localparam int WATCHDOG_CYCLES = N_INSTR * 40 + 200;
    localparam int IDLE_LIMIT = 200;

    typedef struct packed {
        mat_type_t          kind;
        logic [WORD_W-1:0]  addr;
        logic [MAT_S_W-1:0] mat;
        logic [ROW_S_W-1:0] row;
        logic [ROW_W-1:0]   data;
    } exp_row_t;

    logic CLK = 1'b0;
    logic nRST;
    logic instr_valid;
    opcode_t instr_opcode;
    logic [INSTR_ADDR_W-1:0] instr_addr_sel;
    logic [MAT_ID_W-1:0] instr_mat;
    logic psum_valid;
    logic [ROW_S_W-1:0] psum_row;
    logic [ROW_W-1:0] psum_data;
    logic [MAT_ID_W-1:0] gemm_mat;
    logic [NUM_BANKS-1:0] load_hit;
    logic [NUM_BANKS-1:0][ROW_W-1:0] load_data;
    logic [NUM_BANKS-1:0] load_req;
    logic [NUM_BANKS-1:0][WORD_W-1:0] load_addr;
    logic [NUM_BANKS-1:0] rd_valid;
    mat_type_t [NUM_BANKS-1:0] rd_type;
    logic [NUM_BANKS-1:0][WORD_W-1:0] rd_addr;
    logic [NUM_BANKS-1:0][MAT_S_W-1:0] rd_mat;
    logic [NUM_BANKS-1:0][ROW_S_W-1:0] rd_row;
    logic [NUM_BANKS-1:0][ROW_W-1:0] rd_data;

    integer seed = 32'hfa4a_d290;

    // what every matrix should hold, and what each bank still owes
    logic [ROW_W-1:0] shadow [NUM_BANKS][2 ** MAT_S_W][ROWS];
    exp_row_t exp_q [NUM_BANKS][$];
    logic [WORD_W-1:0] load_q [NUM_BANKS][$];
    int load_delay [NUM_BANKS] = '{default: 0};
    logic [ROW_S_W-1:0] hit_row [NUM_BANKS] = '{default: '0};

    scratchpad_top #(
        .INSTR_DEPTH(8),
        .PSUM_DEPTH(4)
    ) dut_i (
        .CLK(CLK),
        .nRST(nRST),
        .instr_valid(instr_valid),
        .instr_opcode(instr_opcode),
        .instr_addr_sel(instr_addr_sel),
        .instr_mat(instr_mat),
        .psum_valid(psum_valid),
        .psum_row(psum_row),
        .psum_data(psum_data),
        .gemm_mat(gemm_mat),
        .load_hit(load_hit),
        .load_data(load_data),
        .load_req(load_req),
        .load_addr(load_addr),
        .rd_valid(rd_valid),
        .rd_type(rd_type),
        .rd_addr(rd_addr),
        .rd_mat(rd_mat),
        .rd_row(rd_row),
        .rd_data(rd_data)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // row contents as DRAM would return them for an address
    function automatic logic [ROW_W-1:0] expected_row(input logic [WORD_W-1:0] addr,
                                                      input logic [ROW_S_W-1:0] r);
        logic [ROW_W-1:0] d;
        int e;
        for (e = 0; e < ROWS; e++) begin
            d[e*ELEM_W +: ELEM_W] = (addr[15:0] ^ addr[31:16])
                                    + ELEM_W'((int'(r) * ROWS + e) * 257);
        end
        return d;
    endfunction

    function automatic int owner(input logic [MAT_ID_W-1:0] id);
        return int'(id[MAT_ID_W-1 -: BANK_SEL_W]);
    endfunction

    function automatic logic [MAT_ID_W-1:0] mat_id(input int bank, input int slot);
        return {BANK_SEL_W'(bank), MAT_S_W'(slot)};
    endfunction

    task automatic report_error(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_row(input int bank, input exp_row_t got, input exp_row_t want);
        if (got.kind !== want.kind) begin
            report_error($sformatf("Fail at %0t: rd_type[%0d] got %s expected %s",
                                   $time, bank, got.kind.name(), want.kind.name()));
        end
        if (got.addr !== want.addr) begin
            report_error($sformatf("Fail at %0t: rd_addr[%0d] got %h expected %h",
                                   $time, bank, got.addr, want.addr));
        end
        if (got.mat !== want.mat) begin
            report_error($sformatf("Fail at %0t: rd_mat[%0d] got %h expected %h",
                                   $time, bank, got.mat, want.mat));
        end
        if (got.row !== want.row) begin
            report_error($sformatf("Fail at %0t: rd_row[%0d] got %h expected %h",
                                   $time, bank, got.row, want.row));
        end
        if (got.data !== want.data) begin
            report_error($sformatf("Fail at %0t: rd_data[%0d] got %h expected %h",
                                   $time, bank, got.data, want.data));
        end
    endtask

    task automatic check_load(input int bank, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] want);
        if (got !== want) begin
            report_error($sformatf("Fail at %0t: load_addr[%0d] got %h expected %h",
                                   $time, bank, got, want));
        end
    endtask

    // all stimulus moves 10 ns after the rising edge
    task automatic next_cycle();
        @(posedge CLK);
        #10;
    endtask

    task automatic send_instr(input opcode_t op, input logic [INSTR_ADDR_W-1:0] sel,
                              input logic [MAT_ID_W-1:0] mat);
        instr_valid = 1'b1;
        instr_opcode = op;
        instr_addr_sel = sel;
        instr_mat = mat;
        next_cycle();
        instr_valid = 1'b0;
    endtask

    task automatic queue_rows(input int bank, input mat_type_t kind,
                              input logic [WORD_W-1:0] addr, input int slot);
        exp_row_t e;
        int r;
        for (r = 0; r < ROWS; r++) begin
            e.kind = kind;
            e.addr = addr;
            e.mat = MAT_S_W'(slot);
            e.row = ROW_S_W'(r);
            e.data = shadow[bank][slot][r];
            exp_q[bank].push_back(e);
        end
    endtask

    task automatic issue_load(input int bank, input int slot, input logic [WORD_W-1:0] addr);
        int r;
        for (r = 0; r < ROWS; r++) begin
            shadow[bank][slot][r] = expected_row(addr, ROW_S_W'(r));
        end
        load_q[bank].push_back(addr);
        send_instr(LOAD, addr, mat_id(bank, slot));
    endtask

    task automatic issue_store(input int bank, input int slot, input logic [WORD_W-1:0] addr);
        queue_rows(bank, STORE_ROW, addr, slot);
        send_instr(STORE, addr, mat_id(bank, slot));
    endtask

    // per bank the order is weight, input, psum
    task automatic issue_gemm(input logic [MAT_ID_W-1:0] w_id, input logic [MAT_ID_W-1:0] in_id,
                              input logic [MAT_ID_W-1:0] ps_id, input logic nw);
        logic [INSTR_ADDR_W-1:0] sel;
        logic [MAT_ID_W-1:0] flags;
        int b;
        for (b = 0; b < NUM_BANKS; b++) begin
            if (nw && owner(w_id) == b) queue_rows(b, WEIGHT_ROW, '0, int'(w_id[MAT_S_W-1:0]));
            if (owner(in_id) == b) queue_rows(b, INPUT_ROW, '0, int'(in_id[MAT_S_W-1:0]));
            if (owner(ps_id) == b) queue_rows(b, PSUM_ROW, '0, int'(ps_id[MAT_S_W-1:0]));
        end
        sel = '0;
        sel[GEMM_IN_LSB +: MAT_ID_W] = in_id;
        sel[GEMM_W_LSB +: MAT_ID_W] = w_id;
        sel[GEMM_PS_LSB +: MAT_ID_W] = ps_id;
        flags = '0;
        flags[NEW_WEIGHT_BIT] = nw;
        send_instr(GEMM, sel, flags);
    endtask

    // gemm_mat stays on the bus until the caller moves it
    task automatic send_psums(input logic [MAT_ID_W-1:0] id);
        logic [ROW_W-1:0] d;
        int r;
        gemm_mat = id;
        for (r = 0; r < ROWS; r++) begin
            d = expected_row({16'hd00d, 10'd0, id}, ROW_S_W'(r));
            shadow[owner(id)][id[MAT_S_W-1:0]][r] = d;
            psum_valid = 1'b1;
            psum_row = ROW_S_W'(r);
            psum_data = d;
            next_cycle();
        end
        psum_valid = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        int b;
        bit busy;
        n = 0;
        busy = 1'b1;
        while (busy) begin
            busy = 1'b0;
            for (b = 0; b < NUM_BANKS; b++) begin
                if (exp_q[b].size() != 0 || load_q[b].size() != 0) busy = 1'b1;
            end
            if (busy) begin
                if (n == IDLE_LIMIT) report_error("banks did not finish their queued work in time");
                next_cycle();
                n++;
            end
        end
        repeat (2) next_cycle();
    endtask

    // DRAM answers each held request after 0 to 3 cycles, one row per hit
    initial begin : dram_model
        int b;
        load_hit = '0;
        load_data = '0;
        forever begin
            next_cycle();
            for (b = 0; b < NUM_BANKS; b++) begin
                load_hit[b] = 1'b0;
                if (nRST && load_req[b]) begin
                    if (load_q[b].size() == 0) begin
                        report_error($sformatf("bank %0d requested a load that was never issued", b));
                    end
                    check_load(b, load_addr[b], load_q[b][0]);
                    if (load_delay[b] == 0) begin
                        load_hit[b] = 1'b1;
                        load_data[b] = expected_row(load_addr[b], hit_row[b]);
                        if (hit_row[b] == ROW_S_W'(ROWS - 1)) void'(load_q[b].pop_front());
                        hit_row[b] = hit_row[b] + 1'b1;
                        load_delay[b] = $random(seed) & 3;
                    end else begin
                        load_delay[b]--;
                    end
                end
            end
        end
    end

    always @(negedge CLK) begin : compare_rows
        exp_row_t got;
        int b;
        if (nRST) begin
            for (b = 0; b < NUM_BANKS; b++) begin
                if (rd_valid[b]) begin
                    if (exp_q[b].size() == 0) begin
                        report_error($sformatf("bank %0d put out a row nobody asked for", b));
                    end
                    got.kind = rd_type[b];
                    got.addr = rd_addr[b];
                    got.mat = rd_mat[b];
                    got.row = rd_row[b];
                    got.data = rd_data[b];
                    check_row(b, got, exp_q[b].pop_front());
                end
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $fatal(1, "run took too long");
    end

    initial begin : stimulus
        logic [WORD_W-1:0] ld_addr [8];
        logic [WORD_W-1:0] st_addr [8];
        int i;
        nRST = 1'b0;
        instr_valid = 1'b0;
        instr_opcode = NOP;
        instr_addr_sel = '0;
        instr_mat = '0;
        psum_valid = 1'b0;
        psum_row = '0;
        psum_data = '0;
        gemm_mat = '0;
        for (i = 0; i < 8; i++) begin
            ld_addr[i] = $random(seed);
            st_addr[i] = $random(seed);
        end
        repeat (5) @(posedge CLK);
        #10;
        nRST = 1'b1;

        repeat (5) begin
            next_cycle();
            if (|load_req || |rd_valid) report_error("bank activity seen before the first instruction");
        end

        // two loads per bank back to back, eight in flight
        for (i = 0; i < 8; i++) issue_load(i % NUM_BANKS, i, ld_addr[i]);
        wait_idle();
        for (i = 0; i < 8; i++) issue_store(i % NUM_BANKS, i, st_addr[i]);
        wait_idle();

        // weight, input and psum in three banks
        issue_gemm(mat_id(0, 0), mat_id(1, 1), mat_id(2, 2), 1'b1);
        wait_idle();
        // weight and input share bank 0
        issue_gemm(mat_id(0, 4), mat_id(0, 0), mat_id(3, 3), 1'b1);
        wait_idle();
        // old weights kept, bank 1 stays quiet
        issue_gemm(mat_id(1, 5), mat_id(2, 6), mat_id(3, 7), 1'b0);
        wait_idle();

        send_psums(mat_id(1, 5));
        issue_store(1, 5, 32'h8000_1500);
        wait_idle();
        gemm_mat = '0;

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/bank_access_fsm.sv ====
`default_nettype none

module bank_access_fsm #(
    parameter int BANK_NUM = 0
) (
    input  logic                                    CLK,
    input  logic                                    nRST,
    input  logic                                    instr_empty,
    input  spad_isa_pkg::opcode_t                   instr_opcode,
    input  logic [spad_isa_pkg::INSTR_ADDR_W-1:0]   instr_addr_sel,
    input  logic [spad_isa_pkg::MAT_ID_W-1:0]       instr_mat,
    output logic                                    instr_ren,
    input  logic                                    psum_full,
    input  logic [spad_pkg::ROW_S_W-1:0]            psum_row,
    input  logic [spad_pkg::ROW_W-1:0]              psum_data,
    input  logic [spad_isa_pkg::MAT_ID_W-1:0]       gemm_mat,
    output logic                                    psum_ren,
    output logic                                    load_req,
    output logic [spad_pkg::WORD_W-1:0]             load_addr,
    input  logic                                    load_hit,
    input  logic [spad_pkg::ROW_W-1:0]              load_data,
    output logic                                    wr_en,
    output logic [spad_pkg::MAT_S_W-1:0]            wr_mat,
    output logic [spad_pkg::ROW_S_W-1:0]            wr_row,
    output logic [spad_pkg::ROW_W-1:0]              wr_data,
    output logic                                    rd_req,
    output spad_pkg::mat_type_t                     rd_req_type,
    output logic [spad_pkg::WORD_W-1:0]             rd_req_addr,
    output logic [spad_pkg::MAT_S_W-1:0]            rd_req_mat,
    output logic [spad_pkg::ROW_S_W-1:0]            rd_req_row
);

    import spad_isa_pkg::*;
    import spad_pkg::*;

    // four-row sequences sit on aligned codes, so the low two bits are the row
    typedef enum logic [4:0] {
        DECODE   = 5'd0,
        PSUMLOAD = 5'd1,
        LOAD0    = 5'd4,  LOAD1    = 5'd5,  LOAD2    = 5'd6,  LOAD3    = 5'd7,
        STORE0   = 5'd8,  STORE1   = 5'd9,  STORE2   = 5'd10, STORE3   = 5'd11,
        W_GEMM0  = 5'd12, W_GEMM1  = 5'd13, W_GEMM2  = 5'd14, W_GEMM3  = 5'd15,
        I_GEMM0  = 5'd16, I_GEMM1  = 5'd17, I_GEMM2  = 5'd18, I_GEMM3  = 5'd19,
        PS_GEMM0 = 5'd20, PS_GEMM1 = 5'd21, PS_GEMM2 = 5'd22, PS_GEMM3 = 5'd23
    } state_t;

    state_t state;
    state_t n_state;
    logic [ROW_S_W-1:0] row;

    logic [WORD_W-1:0] ls_addr;
    logic [MAT_S_W-1:0] ls_mat;
    logic [MAT_ID_W-1:0] in_id;
    logic [MAT_ID_W-1:0] w_id;
    logic [MAT_ID_W-1:0] ps_id;

    function automatic logic owns(input logic [MAT_ID_W-1:0] id);
        return id[MAT_ID_W-1 -: BANK_SEL_W] == BANK_SEL_W'(BANK_NUM);
    endfunction

    // first owned gemm matrix at or after stage (0 weight, 1 input, 2 psum)
    function automatic state_t gemm_seq(input logic [1:0] from, input logic nw,
                                        input logic [MAT_ID_W-1:0] w,
                                        input logic [MAT_ID_W-1:0] i,
                                        input logic [MAT_ID_W-1:0] p);
        state_t s;
        s = DECODE;
        if (from <= 2'd2 && owns(p)) s = PS_GEMM0;
        if (from <= 2'd1 && owns(i)) s = I_GEMM0;
        if (from == 2'd0 && nw && owns(w)) s = W_GEMM0;
        return s;
    endfunction

    assign row = state[ROW_S_W-1:0];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= DECODE;
        end else begin
            state <= n_state;
        end
    end

    always_ff @(posedge CLK) begin
        if (instr_ren) begin
            ls_addr <= instr_addr_sel;
            ls_mat <= instr_mat[MAT_S_W-1:0];
            in_id <= instr_addr_sel[GEMM_IN_LSB +: MAT_ID_W];
            w_id <= instr_addr_sel[GEMM_W_LSB +: MAT_ID_W];
            ps_id <= instr_addr_sel[GEMM_PS_LSB +: MAT_ID_W];
        end
    end

    always_comb begin
        n_state = state;
        instr_ren = 1'b0;
        case (state)
            DECODE: begin
                // a finished result for this bank goes first
                if (psum_full && owns(gemm_mat)) begin
                    n_state = PSUMLOAD;
                end else if (!instr_empty) begin
                    instr_ren = 1'b1;
                    case (instr_opcode)
                        LOAD:    if (owns(instr_mat)) n_state = LOAD0;
                        STORE:   if (owns(instr_mat)) n_state = STORE0;
                        GEMM: begin
                            n_state = gemm_seq(2'd0, instr_mat[NEW_WEIGHT_BIT],
                                               instr_addr_sel[GEMM_W_LSB +: MAT_ID_W],
                                               instr_addr_sel[GEMM_IN_LSB +: MAT_ID_W],
                                               instr_addr_sel[GEMM_PS_LSB +: MAT_ID_W]);
                        end
                        default: n_state = DECODE;
                    endcase
                end
            end
            PSUMLOAD: begin
                if (psum_row == ROW_S_W'(ROWS - 1)) n_state = DECODE;
            end
            LOAD0, LOAD1, LOAD2, LOAD3: begin
                if (load_hit) begin
                    n_state = (state == LOAD3) ? DECODE : state_t'(state + 1'b1);
                end
            end
            STORE0, STORE1, STORE2,
            W_GEMM0, W_GEMM1, W_GEMM2,
            I_GEMM0, I_GEMM1, I_GEMM2,
            PS_GEMM0, PS_GEMM1, PS_GEMM2: n_state = state_t'(state + 1'b1);
            W_GEMM3: n_state = gemm_seq(2'd1, 1'b0, w_id, in_id, ps_id);
            I_GEMM3: n_state = gemm_seq(2'd2, 1'b0, w_id, in_id, ps_id);
            default: n_state = DECODE;
        endcase
    end

    always_comb begin
        psum_ren = 1'b0;
        load_req = 1'b0;
        load_addr = '0;
        wr_en = 1'b0;
        wr_mat = '0;
        wr_row = '0;
        wr_data = '0;
        rd_req = 1'b0;
        rd_req_type = STORE_ROW;
        rd_req_addr = '0;
        rd_req_mat = '0;
        rd_req_row = row;
        case (state)
            PSUMLOAD: begin
                psum_ren = 1'b1;
                wr_en = 1'b1;
                wr_mat = gemm_mat[MAT_S_W-1:0];
                wr_row = psum_row;
                wr_data = psum_data;
            end
            LOAD0, LOAD1, LOAD2, LOAD3: begin
                load_req = 1'b1;
                load_addr = ls_addr;
                // the hit row lands in the bank in the same cycle
                if (load_hit) begin
                    wr_en = 1'b1;
                    wr_mat = ls_mat;
                    wr_row = row;
                    wr_data = load_data;
                end
            end
            STORE0, STORE1, STORE2, STORE3: begin
                rd_req = 1'b1;
                rd_req_addr = ls_addr;
                rd_req_mat = ls_mat;
            end
            W_GEMM0, W_GEMM1, W_GEMM2, W_GEMM3: begin
                rd_req = 1'b1;
                rd_req_type = WEIGHT_ROW;
                rd_req_mat = w_id[MAT_S_W-1:0];
            end
            I_GEMM0, I_GEMM1, I_GEMM2, I_GEMM3: begin
                rd_req = 1'b1;
                rd_req_type = INPUT_ROW;
                rd_req_mat = in_id[MAT_S_W-1:0];
            end
            PS_GEMM0, PS_GEMM1, PS_GEMM2, PS_GEMM3: begin
                rd_req = 1'b1;
                rd_req_type = PSUM_ROW;
                rd_req_mat = ps_id[MAT_S_W-1:0];
            end
        endcase
    end

    // DRAM sees one steady request until it answers
    assert property (@(posedge CLK) disable iff (!nRST)
        load_req && !load_hit |=> load_req && $stable(load_addr))
        else $error("bank %0d: load request dropped or moved before hit", BANK_NUM);

    assert property (@(posedge CLK) disable iff (!nRST)
        wr_en |-> state inside {LOAD0, LOAD1, LOAD2, LOAD3, PSUMLOAD})
        else $error("bank %0d: write outside load or psum drain", BANK_NUM);

endmodule

`default_nettype wire

// ==== logic/scratchpad_top.sv ====
`default_nettype none

module scratchpad_top #(
    parameter int INSTR_DEPTH = 8,
    parameter int PSUM_DEPTH = 4
) (
    input  logic                                                  CLK,
    input  logic                                                  nRST,
    input  logic                                                  instr_valid,
    input  spad_isa_pkg::opcode_t                                 instr_opcode,
    input  logic [spad_isa_pkg::INSTR_ADDR_W-1:0]                 instr_addr_sel,
    input  logic [spad_isa_pkg::MAT_ID_W-1:0]                     instr_mat,
    input  logic                                                  psum_valid,
    input  logic [spad_pkg::ROW_S_W-1:0]                          psum_row,
    input  logic [spad_pkg::ROW_W-1:0]                            psum_data,
    input  logic [spad_isa_pkg::MAT_ID_W-1:0]                     gemm_mat,
    input  logic [spad_pkg::NUM_BANKS-1:0]                        load_hit,
    input  logic [spad_pkg::NUM_BANKS-1:0][spad_pkg::ROW_W-1:0]   load_data,
    output logic [spad_pkg::NUM_BANKS-1:0]                        load_req,
    output logic [spad_pkg::NUM_BANKS-1:0][spad_pkg::WORD_W-1:0]  load_addr,
    output logic [spad_pkg::NUM_BANKS-1:0]                        rd_valid,
    output spad_pkg::mat_type_t [spad_pkg::NUM_BANKS-1:0]         rd_type,
    output logic [spad_pkg::NUM_BANKS-1:0][spad_pkg::WORD_W-1:0]  rd_addr,
    output logic [spad_pkg::NUM_BANKS-1:0][spad_pkg::MAT_S_W-1:0] rd_mat,
    output logic [spad_pkg::NUM_BANKS-1:0][spad_pkg::ROW_S_W-1:0] rd_row,
    output logic [spad_pkg::NUM_BANKS-1:0][spad_pkg::ROW_W-1:0]   rd_data
);

    import spad_isa_pkg::*;
    import spad_pkg::*;

    localparam int INSTR_W = OPCODE_W + INSTR_ADDR_W + MAT_ID_W;
    localparam int PSUM_W = ROW_S_W + ROW_W;

    logic [PSUM_W-1:0] psum_q;
    logic psum_full;
    logic [NUM_BANKS-1:0] psum_ren;

    // shared result queue, drained by whichever bank owns gemm_mat
    sync_fifo #(
        .DEPTH(PSUM_DEPTH),
        .WIDTH(PSUM_W)
    ) u_psum_fifo (
        .CLK,
        .nRST,
        .push(psum_valid),
        .wdata({psum_row, psum_data}),
        .pop(|psum_ren),
        .rdata(psum_q),
        .empty(),
        .full(psum_full)
    );

    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        logic [INSTR_W-1:0] instr_q;
        logic instr_empty;
        logic instr_ren;
        logic wr_en;
        logic [MAT_S_W-1:0] wr_mat;
        logic [ROW_S_W-1:0] wr_row;
        logic [ROW_W-1:0] wr_data;
        logic rq;
        mat_type_t rq_type;
        logic [WORD_W-1:0] rq_addr;
        logic [MAT_S_W-1:0] rq_mat;
        logic [ROW_S_W-1:0] rq_row;

        // each bank keeps its own copy of the instruction stream
        sync_fifo #(
            .DEPTH(INSTR_DEPTH),
            .WIDTH(INSTR_W)
        ) u_instr_fifo (
            .CLK,
            .nRST,
            .push(instr_valid),
            .wdata({instr_opcode, instr_addr_sel, instr_mat}),
            .pop(instr_ren),
            .rdata(instr_q),
            .empty(instr_empty),
            .full()
        );

        bank_access_fsm #(
            .BANK_NUM(b)
        ) u_fsm (
            .CLK,
            .nRST,
            .instr_empty(instr_empty),
            .instr_opcode(opcode_t'(instr_q[INSTR_W-1 -: OPCODE_W])),
            .instr_addr_sel(instr_q[MAT_ID_W +: INSTR_ADDR_W]),
            .instr_mat(instr_q[MAT_ID_W-1:0]),
            .instr_ren(instr_ren),
            .psum_full(psum_full),
            .psum_row(psum_q[ROW_W +: ROW_S_W]),
            .psum_data(psum_q[ROW_W-1:0]),
            .gemm_mat(gemm_mat),
            .psum_ren(psum_ren[b]),
            .load_req(load_req[b]),
            .load_addr(load_addr[b]),
            .load_hit(load_hit[b]),
            .load_data(load_data[b]),
            .wr_en(wr_en),
            .wr_mat(wr_mat),
            .wr_row(wr_row),
            .wr_data(wr_data),
            .rd_req(rq),
            .rd_req_type(rq_type),
            .rd_req_addr(rq_addr),
            .rd_req_mat(rq_mat),
            .rd_req_row(rq_row)
        );

        spad_bank u_bank (
            .CLK,
            .nRST,
            .wr_en(wr_en),
            .wr_mat(wr_mat),
            .wr_row(wr_row),
            .wr_data(wr_data),
            .rd_req(rq),
            .rd_req_type(rq_type),
            .rd_req_addr(rq_addr),
            .rd_req_mat(rq_mat),
            .rd_req_row(rq_row),
            .rd_valid(rd_valid[b]),
            .rd_type(rd_type[b]),
            .rd_addr(rd_addr[b]),
            .rd_mat(rd_mat[b]),
            .rd_row(rd_row[b]),
            .rd_data(rd_data[b])
        );
    end

    // only the owner of the result matrix may pull from the psum queue
    assert property (@(posedge CLK) disable iff (!nRST) $onehot0(psum_ren))
        else $error("scratchpad_top: more than one bank draining psums");

endmodule

`default_nettype wire

// ==== logic/spad_bank.sv ====
`default_nettype none

module spad_bank (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         wr_en,
    input  logic [spad_pkg::MAT_S_W-1:0] wr_mat,
    input  logic [spad_pkg::ROW_S_W-1:0] wr_row,
    input  logic [spad_pkg::ROW_W-1:0]   wr_data,
    input  logic                         rd_req,
    input  spad_pkg::mat_type_t          rd_req_type,
    input  logic [spad_pkg::WORD_W-1:0]  rd_req_addr,
    input  logic [spad_pkg::MAT_S_W-1:0] rd_req_mat,
    input  logic [spad_pkg::ROW_S_W-1:0] rd_req_row,
    output logic                         rd_valid,
    output spad_pkg::mat_type_t          rd_type,
    output logic [spad_pkg::WORD_W-1:0]  rd_addr,
    output logic [spad_pkg::MAT_S_W-1:0] rd_mat,
    output logic [spad_pkg::ROW_S_W-1:0] rd_row,
    output logic [spad_pkg::ROW_W-1:0]   rd_data
);

    import spad_pkg::*;

    localparam int ENTRIES = (2 ** MAT_S_W) * ROWS;

    // one entry per row, indexed by {slot, row}
    logic [ROW_W-1:0] mem [ENTRIES];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_req;
        end
    end

    // a read of the row being written returns the old contents
    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[{wr_mat, wr_row}] <= wr_data;
        end
        if (rd_req) begin
            rd_data <= mem[{rd_req_mat, rd_req_row}];
            rd_type <= rd_req_type;
            rd_addr <= rd_req_addr;
            rd_mat <= rd_req_mat;
            rd_row <= rd_req_row;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        rd_req |=> rd_valid && rd_type == $past(rd_req_type)
                   && rd_addr == $past(rd_req_addr) && rd_mat == $past(rd_req_mat)
                   && rd_row == $past(rd_req_row))
        else $error("spad_bank: read-out tags differ from request");

endmodule

`default_nettype wire

// ==== logic/spad_isa_pkg.sv ====
`default_nettype none

package spad_isa_pkg;

    localparam int OPCODE_W = 2;

    // external address for load and store, packed matrix ids for gemm
    localparam int INSTR_ADDR_W = 32;

    // top two bits pick the bank, low four bits the slot
    localparam int MAT_ID_W = 6;

    // for gemm the matrix field only carries the new weight flag
    localparam int NEW_WEIGHT_BIT = 5;

    // gemm id offsets inside the address/select word
    localparam int GEMM_IN_LSB = 12;
    localparam int GEMM_W_LSB = 6;
    localparam int GEMM_PS_LSB = 0;

    typedef enum logic [OPCODE_W-1:0] {
        NOP   = 2'd0,
        LOAD  = 2'd1,
        STORE = 2'd2,
        GEMM  = 2'd3
    } opcode_t;

endpackage

`default_nettype wire

// ==== logic/spad_pkg.sv ====
`default_nettype none

package spad_pkg;

    localparam int NUM_BANKS = 4;
    localparam int BANK_SEL_W = 2;

    // 16 matrices per bank
    localparam int MAT_S_W = 4;

    localparam int ROWS = 4;
    localparam int ROW_S_W = 2;

    // one row packs four elements
    localparam int ELEM_W = 16;
    localparam int ROW_W = ROWS * ELEM_W;

    localparam int WORD_W = 32;

    // tag carried with every row read out of a bank
    typedef enum logic [1:0] {
        STORE_ROW  = 2'd0,
        INPUT_ROW  = 2'd1,
        WEIGHT_ROW = 2'd2,
        PSUM_ROW   = 2'd3
    } mat_type_t;

endpackage

`default_nettype wire

// ==== logic/sync_fifo.sv ====
`default_nettype none

module sync_fifo #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32
) (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             push,
    input  logic [WIDTH-1:0] wdata,
    input  logic             pop,
    output logic [WIDTH-1:0] rdata,
    output logic             empty,
    output logic             full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] rptr;
    logic [PTR_W-1:0] wptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    // a full queue still accepts a push when the head leaves in the same cycle
    assign do_pop = pop && !empty;
    assign do_push = push && (!full || do_pop);

    assign empty = (count == '0);
    assign full = (count == CNT_W'(DEPTH));

    // first word fall through
    assign rdata = mem[rptr];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rptr <= '0;
            wptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wptr <= (wptr == PTR_W'(DEPTH - 1)) ? '0 : wptr + 1'b1;
            end
            if (do_pop) begin
                rptr <= (rptr == PTR_W'(DEPTH - 1)) ? '0 : rptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (do_push) begin
            mem[wptr] <= wdata;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) push && full |-> pop)
        else $error("sync_fifo: push into full queue");

    assert property (@(posedge CLK) disable iff (!nRST) pop |-> !empty)
        else $error("sync_fifo: pop from empty queue");

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/spad_isa_pkg.sv
logic/spad_pkg.sv
logic/sync_fifo.sv
logic/spad_bank.sv
logic/bank_access_fsm.sv
logic/scratchpad_top.sv
dv/scratchpad_tb.sv
